/* design/branchCondition.sv */
`default_nettype none

// Transfer class decode and taken decision
// The only block that looks at opcode conditions
module branchCondition (
	input dlxPkg::wordT instr, // Fetched instruction word
	input dlxPkg::wordT rs1Val, // Value of rs1 for the zero test
	output dlxPkg::xferKindT kind, // Decoded transfer class
	output logic taken // Transfer happens
);

	import dlxPkg::*;

	opcodeT opcode;
	logic rs1Zero; // rs1 reads as zero
	logic branchOnZero; // beqz sense, bnez when low

	assign opcode = opcodeT'(instr[opcodeLsb +: opcodeWidth]);

	// Full-word compare against zero
	assign rs1Zero = (rs1Val == '0);

	// Opcode to class
	always_comb begin
		branchOnZero = 1'b0;
		unique case (opcode)
			opJ: begin
				kind = xferJump;
			end
			opJal: begin
				kind = xferJumpLink;
			end
			opJr: begin
				kind = xferReg;
			end
			opBeqz: begin
				kind = xferBranch;
				branchOnZero = 1'b1;
			end
			opBnez: begin
				kind = xferBranch; // branchOnZero stays low
			end
			default: begin
				kind = xferNone;
			end
		endcase
	end

	// Taken decision per class
	always_comb begin
		unique case (kind)
			xferJump, xferJumpLink, xferReg: begin
				taken = 1'b1; // Unconditional
			end
			xferBranch: begin
				// Zero for beqz, nonzero for bnez
				taken = branchOnZero ? rs1Zero : !rs1Zero;
			end
			default: begin
				taken = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/branchTarget.sv */
`default_nettype none

// Target address generation for j, jal, jr, beqz and bnez
// Pure combinational, no knowledge of whether the transfer is taken
module branchTarget (
	input dlxPkg::wordT pc, // Address of the current instruction
	input dlxPkg::wordT instr, // Fetched instruction word
	input dlxPkg::wordT rs1Val, // Value of rs1, used by jr
	output dlxPkg::wordT targetPc, // Address if the transfer is taken
	output dlxPkg::wordT fallPc, // PC + 4
	output dlxPkg::wordT linkVal // PC + 8, destined for r31
);

	import dlxPkg::*;

	opcodeT opcode; // Opcode field, typed for the case below
	logic [nameWidth-1:0] nameField; // Raw J-type offset
	logic [immWidth-1:0] immField; // Raw I-type offset
	wordT nameExt; // Sign-extended name
	wordT immExt; // Sign-extended immediate
	wordT nameTarget; // Target of j and jal
	wordT immTarget; // Target of beqz and bnez

	// Field extraction
	assign opcode = opcodeT'(instr[opcodeLsb +: opcodeWidth]);
	assign nameField = instr[nameWidth-1:0];
	assign immField = instr[immWidth-1:0];

	// Replicate the sign bit up to a full word
	assign nameExt = {{(32 - nameWidth){nameField[nameWidth-1]}}, nameField};
	assign immExt = {{(32 - immWidth){immField[immWidth-1]}}, immField};

	// Sequential addresses
	assign fallPc = pc + pcStep;
	assign linkVal = fallPc + pcStep; // Return address skips the delay slot position

	// Both offset adders work from PC + 4, as in DLX
	assign nameTarget = fallPc + nameExt;
	assign immTarget = fallPc + immExt;

	// Pick the target by opcode class
	always_comb begin
		unique case (opcode)
			opJr: begin
				targetPc = rs1Val; // Register indirect, taken as is, even unaligned
			end
			opJ, opJal: begin
				targetPc = nameTarget;
			end
			opBeqz, opBnez: begin
				targetPc = immTarget; // Only used if the condition holds
			end
			default: begin
				targetPc = fallPc; // No transfer
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/dlxBranchStage.sv */
`default_nettype none

// Next-PC stage of the DLX pipeline
// Target generation and condition decode run side by side,
// nextPcSelect merges them and owns the PC
module dlxBranchStage (
	input logic clk,
	input logic rstN, // Async, active low
	input dlxPkg::wordT instr, // Instruction fetched at pc
	input dlxPkg::wordT rs1Val, // Register rs1 of that instruction
	input logic instrValid, // instr and rs1Val are valid
	input logic stall, // Hold off acceptance
	output dlxPkg::wordT pc, // Fetch address
	output logic redirect, // Control flow changed
	output logic linkWe, // r31 write strobe
	output dlxPkg::wordT linkData // r31 write data
);

	import dlxPkg::*;

	wordT targetPc; // Taken address
	wordT fallPc; // Sequential address
	wordT linkVal; // Return address
	xferKindT kind; // Transfer class
	logic taken; // Transfer decision

	// Address side, works from the registered pc
	branchTarget branchTarget_inst (
		.pc(pc),
		.instr(instr),
		.rs1Val(rs1Val),
		.targetPc(targetPc),
		.fallPc(fallPc),
		.linkVal(linkVal)
	);

	// Decision side
	branchCondition branchCondition_inst (
		.instr(instr),
		.rs1Val(rs1Val),
		.kind(kind),
		.taken(taken)
	);

	// Merge and register
	nextPcSelect nextPcSelect_inst (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.stall(stall),
		.targetPc(targetPc),
		.fallPc(fallPc),
		.linkVal(linkVal),
		.kind(kind),
		.taken(taken),
		.pc(pc),
		.redirect(redirect),
		.linkWe(linkWe),
		.linkData(linkData)
	);

endmodule

`default_nettype wire

/* design/dlxPkg.sv */
`default_nettype none

// Shared types and constants for the DLX next-PC stage
package dlxPkg;

	// Machine word, used for PC, instruction, register and address values
	typedef logic [31:0] wordT;

	// Instruction field layout
	localparam int opcodeLsb = 26; // Opcode sits in instr[31:26]
	localparam int opcodeWidth = 6;
	localparam int nameWidth = 26; // J-type name field, instr[25:0]
	localparam int immWidth = 16; // I-type immediate, instr[15:0]

	// Opcodes of the five control transfers handled here
	typedef enum logic [opcodeWidth-1:0] {
		opJ = 6'h02, // PC = PC + 4 + sext(name)
		opJal = 6'h03, // Same target, r31 = PC + 8
		opBeqz = 6'h04, // Taken when rs1 is zero
		opBnez = 6'h05, // Taken when rs1 is not zero
		opJr = 6'h12 // PC = rs1
	} opcodeT;

	// Decoded transfer class, handed from the decoder to the PC register stage
	typedef enum logic [2:0] {
		xferNone, // Plain fall-through
		xferJump, // j
		xferJumpLink, // jal, also writes the link register
		xferReg, // jr
		xferBranch // beqz or bnez
	} xferKindT;

	// PC after reset
	localparam wordT resetPc = 32'h0000_0000;

	// Address step between sequential instructions
	localparam wordT pcStep = 32'd4;

	// Link register written by jal with PC + 8
	localparam logic [4:0] linkReg = 5'd31;

endpackage

`default_nettype wire

/* design/nextPcSelect.sv */
`default_nettype none

// PC register and result registers of the stage
// Loads the next PC on an accepting edge, holds under stall or idle
module nextPcSelect (
	input logic clk,
	input logic rstN, // Async, active low
	input logic instrValid, // Instruction is presented
	input logic stall, // Back-pressure, nothing is consumed
	input dlxPkg::wordT targetPc, // Taken address
	input dlxPkg::wordT fallPc, // PC + 4
	input dlxPkg::wordT linkVal, // PC + 8
	input dlxPkg::xferKindT kind, // Transfer class from the decoder
	input logic taken, // Transfer decision from the decoder
	output dlxPkg::wordT pc, // Current PC
	output logic redirect, // Last accepted instruction changed flow
	output logic linkWe, // Write linkData to r31 this cycle
	output dlxPkg::wordT linkData // Return address for r31
);

	import dlxPkg::*;

	logic accept; // Instruction consumed on this edge
	logic isLink; // Accepted instruction is jal
	wordT nextPc; // Address loaded into pc on accept

	// Handshake
	assign accept = instrValid && !stall;

	// Class check only, the condition itself was settled upstream
	assign isLink = (kind == xferJumpLink);

	// Taken picks the target, otherwise fall through
	assign nextPc = taken ? targetPc : fallPc;

	// PC register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (accept) begin
			pc <= nextPc;
		end
	end

	// One-cycle flags, low whenever nothing was accepted
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			redirect <= 1'b0;
			linkWe <= 1'b0;
		end else if (accept) begin
			redirect <= taken;
			linkWe <= isLink; // Pulse for the accepting cycle only
		end else begin
			redirect <= 1'b0;
			linkWe <= 1'b0;
		end
	end

	// Link payload, keeps the last written value between jal instructions
	always_ff @(posedge clk) begin
		if (accept && isLink) begin
			linkData <= linkVal;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the next-PC stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module dlxBranchStageTb \
	-f vlog.f \
	-o dlxBranchStageSim

./obj_dir/dlxBranchStageSim | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

/* tests/branchTrace.txt */
// Columns, all hex: test, instr, rs1Val, stall cycles, pc, redirect, linkWe, linkData
// linkData is compared from the first jal on, pc values chain from reset at 0
// Non-transfer opcodes fall through to pc+4
01 00221820 00000000 0 00000004 0 0 00000000 // add
02 20410005 12345678 0 00000008 0 0 00000000 // addi
03 8c620010 00000000 0 0000000c 0 0 00000000 // lw
04 18000040 00000000 0 00000010 0 0 00000000 // Opcode 06, next to bnez
05 4c600000 00000100 0 00000014 0 0 00000000 // Opcode 13, not handled here
// j and jal, target is pc+4 plus sext(name)
06 08000100 00000000 0 00000118 1 0 00000000 // j +100
07 0c000040 00000000 0 0000015c 1 1 00000120 // jal +40
08 0bffffe0 00000000 0 00000140 1 0 00000120 // j -20
09 0fffff00 00000000 0 00000044 1 1 00000148 // jal -100
0a 0a000000 00000000 0 fe000048 1 0 00000148 // Most negative name
0b 09fffffc 00000000 0 00000048 1 0 00000148 // Largest positive name, wraps
// jr takes rs1 as is
0c 48200000 00002000 0 00002000 1 0 00000148
0d 48200000 00003003 0 00003003 1 0 00000148 // Unaligned
0e 48200000 ffffffff 0 ffffffff 1 0 00000148 // All ones
0f 00000000 00000000 0 00000003 0 0 00000148 // Fall-through wraps past zero
10 48200000 00001000 0 00001000 1 0 00000148
// beqz and bnez, taken and not taken
11 10200020 00000000 0 00001024 1 0 00000148 // beqz zero, taken
12 10200020 00000001 0 00001028 0 0 00000148 // beqz one
13 10200020 80000000 0 0000102c 0 0 00000148 // beqz top bit
14 1420fff0 00000000 0 00001030 0 0 00000148 // bnez zero
15 1420fff0 00000001 0 00001024 1 0 00000148 // bnez one, back by 10
16 14200100 80000000 0 00001128 1 0 00000148 // bnez top bit
17 10207ffc 00000000 0 00009128 1 0 00000148 // Largest positive immediate
18 14208000 ffffffff 0 0000112c 1 0 00000148 // Most negative immediate
// Stalled instructions, accepted once
19 0c000010 00000000 3 00001140 1 1 00001134 // jal held off 3 cycles
1a 10200008 00000000 2 0000114c 1 0 00001134
1b 00000000 00000000 4 00001150 0 0 00001134
1c 48200000 00002000 1 00002000 1 0 00001134
1d 0ffff000 00000000 2 00001004 1 1 00002008 // jal -1000
1e 00221820 00000000 0 00001008 0 0 00002008 // Link strobe gone
1f 0c000000 00000000 0 0000100c 1 1 00001010 // jal +0 still redirects
20 00000000 00000000 0 00001010 0 0 00001010

/* tests/dlxBranchStageTb.sv */
`default_nettype none

// Trace-driven testbench for the DLX next-PC stage
module dlxBranchStageTb;

	import dlxPkg::*;

	localparam int traceCols = 8; // Words per trace line
	localparam int maxLines = 64;
	localparam int maxStall = 4; // Largest stall count used in the trace
	localparam int maxIdle = 3; // Largest random idle gap between lines
	localparam int resetCycles = 16;

	logic clk;
	logic rstN;
	wordT instr;
	wordT rs1Val;
	logic instrValid;
	logic stall;
	wordT pc;
	logic redirect;
	logic linkWe;
	wordT linkData;

	wordT traceMem [0:traceCols*maxLines-1]; // Flat image of the trace file
	int lineCount;
	int cycleCount;
	int cycleLimit; // Derived from the trace length
	int testErrors; // Mismatches in the running test
	int passCount;
	int failCount;
	logic linkKnown; // linkData holds a defined value after the first jal

	dlxBranchStage dlxBranchStage_inst (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.rs1Val(rs1Val),
		.instrValid(instrValid),
		.stall(stall),
		.pc(pc),
		.redirect(redirect),
		.linkWe(linkWe),
		.linkData(linkData)
	);

	always #50 clk = ~clk; // Period 100

	// Cycle budget for the whole run
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Simulation timed out after %0d cycles", cycleCount);
			$display("tests failed");
			$finish;
		end
	end

	task automatic checkWord(input string name, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			testErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
			testErrors++;
		end
	endtask

	// Nothing accepted so flags stay low and pc holds
	task automatic checkIdleFlags(input wordT heldPc);
		checkBit("redirect", redirect, 1'b0);
		checkBit("linkWe", linkWe, 1'b0);
		checkWord("pc", pc, heldPc);
	endtask

	// Wait through the sampling rising edge to the next falling edge
	task automatic nextCycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic reportTest(input string label);
		if (testErrors == 0) begin
			passCount++;
			$display("%s passed", label);
		end else begin
			failCount++;
			$display("%s failed with %0d mismatches", label, testErrors);
		end
	endtask

	// One trace line with random idle gap and stall cycles before the accepting edge
	task automatic runLine(input int line);
		int base;
		int idleCycles;
		wordT heldPc;
		base = line * traceCols;
		testErrors = 0;
		heldPc = pc;
		idleCycles = $urandom % (maxIdle + 1);
		repeat (idleCycles) begin
			instr = $urandom; // Garbage on the bus while invalid
			rs1Val = $urandom;
			instrValid = 1'b0;
			stall = 1'b0;
			nextCycle();
			checkIdleFlags(heldPc);
		end
		instr = traceMem[base + 1];
		rs1Val = traceMem[base + 2];
		instrValid = 1'b1;
		stall = 1'b1; // Same instruction stays on the bus while stalled
		repeat (traceMem[base + 3]) begin
			nextCycle();
			checkIdleFlags(heldPc);
		end
		stall = 1'b0;
		nextCycle(); // Accepting edge
		checkWord("pc", pc, traceMem[base + 4]);
		checkBit("redirect", redirect, traceMem[base + 5][0]);
		checkBit("linkWe", linkWe, traceMem[base + 6][0]);
		if (traceMem[base + 6][0]) begin
			linkKnown = 1'b1;
		end
		if (linkKnown) begin
			checkWord("linkData", linkData, traceMem[base + 7]);
		end
		instrValid = 1'b0;
		reportTest($sformatf("Test %0d", traceMem[base]));
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		rs1Val = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		cycleCount = 0;
		passCount = 0;
		failCount = 0;
		testErrors = 0;
		linkKnown = 1'b0;
		void'($urandom(32'h35a3_0a71));
		for (int i = 0; i < traceCols * maxLines; i++) begin
			traceMem[i] = '0; // Test number zero marks the end of the trace
		end
		$readmemh("tests/branchTrace.txt", traceMem);
		lineCount = 0;
		while (lineCount < maxLines && traceMem[lineCount * traceCols] != '0) begin
			lineCount++;
		end
		cycleLimit = resetCycles + lineCount * (maxStall + maxIdle + 2) + 20;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;

		// State right after reset
		checkWord("pc", pc, resetPc);
		checkBit("redirect", redirect, 1'b0);
		checkBit("linkWe", linkWe, 1'b0);
		reportTest("Reset check");

		if (lineCount == 0) begin
			$display("Trace file is empty or could not be read");
			failCount++;
		end
		for (int line = 0; line < lineCount; line++) begin
			runLine(line);
		end

		$display("Summary: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/dlxPkg.sv
design/branchTarget.sv
design/branchCondition.sv
design/nextPcSelect.sv
design/dlxBranchStage.sv
tests/dlxBranchStageTb.sv
